// File: hit_readout_trace.txt
# Records: M <A always | R random | S stall> <low cycles>, H <hit hex>, E <packed hex>, L <level>
# Packed word is {second tagged word, first tagged word}, tagged word is {tag, hit}
# Always ready, tags count up from 0 and wrap after 15
M A 0
H 5a1 H 3c2 E 13c205a1
H 7e3 H 0f4 E 30f427e3
H 915 H b26 E 5b264915
H d37 H 148 E 71486d37
H 659 H a6a E 9a6a8659
H c7b H 28c E b28cac7b
H e9d H 4ae E d4aece9d
H 8bf H fc0 E ffc0e8bf
# Ninth word holds tags 0 and 1 again
H 3d1 H ae2 E 1ae203d1
H 5f3 H c04 E 3c0425f3
# Random out_ready and gaps in in_valid
M R 0
H 111 H 222 E 52224111
H f0f H 0f0 E 70f06f0f
H abc H def E 9def8abc
# Output stalled until in_ready stays low for 20 cycles
M S 20
H 001 H 002 E b002a001
H 004 H 008 E d008c004
H 010 H 020 E f020e010
H 040 H 080 E 10800040
H 100 H 200 E 32002100
H 400 H 800 E 58004400
H fff H 555 E 75556fff
L 7
# Release the output, the last hit goes in now
M A 0

// File: hit_readout.f
+incdir+.
readout_pkg.sv
hit_tagger.sv
sync_fifo.sv
fifo_reader.sv
word_packer.sv
hit_readout_top.sv
hit_readout_props.sv
hit_readout_tb.sv

// File: Makefile
# Verilator build and run of the hit readout testbench

TOP = hit_readout_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f hit_readout.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: hit_readout_tb.sv
// Trace-driven testbench of the hit readout path
// Clock, reset, hit stimulus, out_ready patterns and output checks
// Watchdog sized from the number of hits in the trace

`timescale 1ns/1ns

`include "readout_config.svh"

module hit_readout_tb
    import readout_pkg::*;
();

    logic         clk;
    logic         reset;
    logic         in_valid;
    hit_data_t    in_data;
    logic         out_ready;
    logic         in_ready;
    logic         out_valid;
    packed_word_t out_data;
    fifo_level_t  fill_level;

    integer       seed;
    logic [7:0]   mode;
    int           stall_limit;
    logic         hit_pending;
    logic         trace_loaded;
    int           hit_total;
    int           e_count;
    int           seen_count = 0;

    // Trace records in file order
    logic [7:0]   rec_kind [$];
    logic [7:0]   rec_mode [$];
    logic [31:0]  rec_val [$];
    packed_word_t expected_q [$];

    hit_readout_top u_hit_readout_top (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .fill_level (fill_level)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_packed(input string name, input packed_word_t expected,
                                input packed_word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH at %0t ns: %s expected %h, seen %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_level(input string name, input fifo_level_t expected,
                               input fifo_level_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH at %0t ns: %s expected %0d, seen %0d",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH at %0t ns: %s expected %b, seen %b",
                               $time, name, expected, actual));
        end
    endtask

    // Reads all records, comment lines start with #
    task automatic load_trace();
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [7:0]       mode_ch;
        logic [31:0]      value;
        logic [8*128-1:0] line;
        fd = $fopen("hit_readout_trace.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open the trace file hit_readout_trace.txt");
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            mode_ch = 8'h00;
            value   = '0;
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else begin
                if (kind == "M") begin
                    code = $fscanf(fd, " %c %d", mode_ch, value);
                end else begin
                    code = $fscanf(fd, "%h", value);
                end
                if (code < 1) begin
                    fail_run("Trace record without a value");
                end
                if (kind == "H") begin
                    hit_total++;
                end else if (kind == "E") begin
                    expected_q.push_back(value);
                end else if (kind != "M" && kind != "L") begin
                    fail_run($sformatf("Unknown trace record %c", kind));
                end
                rec_kind.push_back(kind);
                rec_mode.push_back(mode_ch);
                rec_val.push_back(value);
            end
        end
        $fclose(fd);
    endtask

    // Holds the offered hit until taken, or gives up after limit low cycles
    task automatic wait_accept(input int limit);
        int low_cycles;
        low_cycles = 0;
        while (!in_ready && (limit == 0 || low_cycles < limit)) begin
            low_cycles++;
            @(negedge clk);
        end
        if (in_ready) begin
            @(negedge clk);
            in_valid    = 1'b0;
            hit_pending = 1'b0;
        end else begin
            hit_pending = 1'b1;
        end
    endtask

    task automatic send_hit(input hit_data_t value);
        int gap;
        if (mode == "R") begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
        end
        in_valid = 1'b1;
        in_data  = value;
        wait_accept((mode == "S") ? stall_limit : 0);
    endtask

    task automatic wait_outputs(input int target);
        while (seen_count < target) begin
            @(negedge clk);
        end
    endtask

    initial begin : stimulus
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        seed         = 41;
        mode         = "A";
        stall_limit  = 0;
        hit_pending  = 1'b0;
        hit_total    = 0;
        e_count      = 0;
        trace_loaded = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_flag("in_ready", 1'b1, in_ready);
        check_flag("out_valid", 1'b0, out_valid);
        check_level("fill_level", '0, fill_level);
        for (int i = 0; i < rec_kind.size(); i++) begin
            case (rec_kind[i])
                "M": begin
                    // Stall starts from an empty path
                    if (rec_mode[i] == "S") begin
                        wait_outputs(e_count);
                    end
                    mode        = rec_mode[i];
                    stall_limit = rec_val[i];
                    if (hit_pending) begin
                        wait_accept(0);
                    end
                end
                "H": begin
                    if (hit_pending) begin
                        fail_run("Trace offers a new hit while the DUT still refuses the last one");
                    end
                    send_hit(hit_data_t'(rec_val[i]));
                end
                "E": e_count++;
                default: begin
                    check_flag("in_ready", 1'b0, in_ready);
                    check_level("fill_level", fifo_level_t'(rec_val[i]), fill_level);
                end
            endcase
        end
        if (hit_pending) begin
            wait_accept(0);
        end
        wait_outputs(e_count);
        // Room for a stray extra word to show up
        repeat (10) @(negedge clk);
        if (seen_count == e_count && expected_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run("Output words left unchecked at the end of the trace");
        end
    end

    // out_ready pattern and output monitor
    initial begin : output_side
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            case (mode)
                "R": out_ready = ($random(seed) & 1) != 0;
                "S": out_ready = 1'b0;
                default: out_ready = 1'b1;
            endcase
            // Transfer completes at the coming rising edge
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    fail_run("Output word arrived after all expected words");
                end
                check_packed("out_data", expected_q.pop_front(), out_data);
                seen_count++;
            end
        end
    end

    initial begin : watchdog
        wait (trace_loaded);
        repeat (hit_total * 40 + 200) @(posedge clk);
        fail_run("Output stream stopped before all expected words arrived");
    end

endmodule

// File: hit_readout_props.sv
// Concurrent checks on the hit readout path
// Output handshake, FIFO flags and fill level range
// Bound into the top level

`timescale 1ns/1ns

`include "readout_config.svh"

module hit_readout_props
    import readout_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         out_valid,
    input logic         out_ready,
    input packed_word_t out_data,
    input logic         full,
    input logic         read,
    input fifo_level_t  fill_level
);

    // Stalled output word waits unchanged for out_ready
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_valid or out_data changed before out_ready");

    // Only a read may change the level while full
    assert property (@(posedge clk) disable iff (reset)
        full |=> fill_level == $past(fill_level) - fifo_level_t'($past(read)))
        else $error("FIFO accepted a write while full");

    // No read reaches a FIFO that holds nothing
    assert property (@(posedge clk) disable iff (reset)
        fill_level == '0 |-> !read)
        else $error("FIFO read issued while empty");

    // Top of the level range coincides with full
    assert property (@(posedge clk) disable iff (reset)
        full == (int'(fill_level) == `FIFO_DEPTH - 1))
        else $error("fill_level and full disagree");

endmodule

bind hit_readout_top hit_readout_props u_hit_readout_props (
    .clk        (clk),
    .reset      (reset),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .full       (full),
    .read       (read),
    .fill_level (fill_level)
);

// File: hit_readout_top.sv
// Hit readout path top level
// Tagger, tagged-word FIFO, FIFO reader and word packer in a chain
// FIFO fill level brought out as status

`timescale 1ns/1ns

`include "readout_config.svh"

module hit_readout_top
    import readout_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  hit_data_t    in_data,
    input  logic         out_ready,
    output logic         in_ready,
    output logic         out_valid,
    output packed_word_t out_data,
    output fifo_level_t  fill_level
);

    // Tagger to FIFO
    logic         tag_valid;
    tagged_word_t tag_word;
    logic         full;

    // FIFO to reader
    logic         read;
    logic         empty;
    tagged_word_t data_out;

    // Reader to packer
    logic         word_valid;
    tagged_word_t word_data;
    logic         word_ready;

    hit_tagger u_hit_tagger (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .full      (full),
        .in_ready  (in_ready),
        .tag_valid (tag_valid),
        .tag_word  (tag_word)
    );

    sync_fifo #(
        .DATA_WIDTH (`TAG_WIDTH + `HIT_WIDTH),
        .DEPTH      (`FIFO_DEPTH)
    ) u_sync_fifo (
        .clk      (clk),
        .reset    (reset),
        .write    (tag_valid),
        .read     (read),
        .data_in  (tag_word),
        .full     (full),
        .empty    (empty),
        .data_out (data_out),
        .size     (fill_level)
    );

    fifo_reader u_fifo_reader (
        .clk        (clk),
        .reset      (reset),
        .empty      (empty),
        .data_out   (data_out),
        .word_ready (word_ready),
        .read       (read),
        .word_valid (word_valid),
        .word_data  (word_data)
    );

    word_packer u_word_packer (
        .clk        (clk),
        .reset      (reset),
        .word_valid (word_valid),
        .word_data  (word_data),
        .out_ready  (out_ready),
        .word_ready (word_ready),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

// File: word_packer.sv
// Output stage of the readout path
// Pairs two tagged words into one packed output word
// First word lands in the lower half, second in the upper half

`timescale 1ns/1ns

module word_packer
    import readout_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         word_valid,
    input  tagged_word_t word_data,
    input  logic         out_ready,
    output logic         word_ready,
    output logic         out_valid,
    output packed_word_t out_data
);

    packer_state_t state;
    tagged_word_t  low_q;
    packed_word_t  out_q;
    logic          out_valid_q;
    logic          out_free;
    logic          accept;

    // Output register is empty or drains this cycle
    assign out_free = !out_valid_q || out_ready;

    // A first half can always be parked
    assign word_ready = (state == EMPTY_HALF) || out_free;
    assign accept     = word_valid && word_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= EMPTY_HALF;
            out_valid_q <= 1'b0;
        end else begin
            case (state)
                EMPTY_HALF: begin
                    if (accept) begin
                        state <= LOW_HALF_HELD;
                    end
                    if (out_ready) begin
                        out_valid_q <= 1'b0;
                    end
                end
                LOW_HALF_HELD: begin
                    if (accept) begin
                        state       <= EMPTY_HALF;
                        out_valid_q <= 1'b1;
                    end else if (out_ready) begin
                        out_valid_q <= 1'b0;
                    end
                end
                default: state <= EMPTY_HALF;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == EMPTY_HALF) begin
            low_q <= word_data;
        end
        if (accept && state == LOW_HALF_HELD) begin
            out_q <= {word_data, low_q};
        end
    end

    assign out_valid = out_valid_q;
    assign out_data  = out_q;

endmodule

// File: fifo_reader.sv
// Read side of the FIFO
// Issues reads and turns the one-cycle read latency back into
// a valid/ready stream through a two-entry skid buffer

`timescale 1ns/1ns

module fifo_reader
    import readout_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         empty,
    input  tagged_word_t data_out,
    input  logic         word_ready,
    output logic         read,
    output logic         word_valid,
    output tagged_word_t word_data
);

    tagged_word_t skid [2];
    logic [1:0]   held;
    logic         pend;
    logic         pop;
    logic         skid_pop;
    logic         push;

    // Read only while the returning word still has a place
    assign read = !empty && ((held + pend) < 2'd2);

    // Skid head first, else the word returning from the FIFO this cycle
    assign word_valid = (held != 2'd0) || pend;
    assign word_data  = (held != 2'd0) ? skid[0] : data_out;

    assign pop      = word_valid && word_ready;
    assign skid_pop = pop && (held != 2'd0);
    // Returning word goes to the skid unless it was taken straight away
    assign push     = pend && !(pop && (held == 2'd0));

    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= 1'b0;
            held <= 2'd0;
        end else begin
            pend <= read;
            held <= held + push - skid_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_pop) begin
            // Shift up, or refill the head from the returning word
            skid[0] <= (held == 2'd2) ? skid[1] : data_out;
        end else if (push) begin
            skid[held[0]] <= data_out;
        end
    end

endmodule

// File: sync_fifo.sv
// Synchronous circular FIFO
// Wrapping read and write pointers over a register memory
// Registered empty with read look-ahead, combinational full
// Registered read data and pointer-distance fill level

`timescale 1ns/1ns

module sync_fifo #(
    parameter int DATA_WIDTH = 16,
    parameter int DEPTH      = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write,
    input  logic                     read,
    input  logic [DATA_WIDTH-1:0]    data_in,
    output logic                     full,
    output logic                     empty,
    output logic [DATA_WIDTH-1:0]    data_out,
    output logic [$clog2(DEPTH)-1:0] size
);

    localparam int PTR_WIDTH = $clog2(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH-1:0] wr_inc;
    logic [PTR_WIDTH-1:0] rd_inc;
    logic                 do_write;
    logic                 do_read;

    // Depth is a power of two, so the increments wrap on their own
    assign wr_inc = wr_ptr + 1'b1;
    assign rd_inc = rd_ptr + 1'b1;

    // One slot always stays free to tell full from empty
    assign full = (wr_inc == rd_ptr);

    assign do_write = write && !full;
    assign do_read  = read && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_inc;
        end
    end

    // Look ahead past the read in progress
    // A write in the same cycle shows up one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            empty <= 1'b1;
        end else if (do_read) begin
            empty <= (wr_ptr == rd_inc);
        end else begin
            empty <= (wr_ptr == rd_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Read word is on data_out the cycle after the read
    always_ff @(posedge clk) begin
        if (do_read) begin
            data_out <= mem[rd_ptr];
        end
    end

    // Fill level, with the write pointer behind the read pointer after a wrap
    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            size = wr_ptr - rd_ptr;
        end else begin
            size = PTR_WIDTH'(DEPTH + wr_ptr - rd_ptr);
        end
    end

endmodule

// File: hit_tagger.sv
// Input stage of the readout path
// Registers one hit and stamps it with a running sequence tag
// Feeds the FIFO write port, with full as back-pressure

`timescale 1ns/1ns

module hit_tagger
    import readout_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  hit_data_t    in_data,
    input  logic         full,
    output logic         in_ready,
    output logic         tag_valid,
    output tagged_word_t tag_word
);

    logic         valid_q;
    tagged_word_t word_q;
    hit_tag_t     tag_cnt;
    logic         accept;

    // Free when empty or when the held word enters the FIFO this cycle
    assign in_ready = !valid_q || !full;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            tag_cnt <= '0;
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
                // Wraps back to zero after the last tag value
                tag_cnt <= tag_cnt + 1'b1;
            end else if (!full) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Hit gets the tag before the increment
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= {tag_cnt, in_data};
        end
    end

    assign tag_valid = valid_q;
    assign tag_word  = word_q;

endmodule

// File: readout_pkg.sv
// Shared types of the hit readout path
// Vector typedefs for hits, tags, tagged and packed words
// Packer state enum

`include "readout_config.svh"

package readout_pkg;

    typedef logic [`HIT_WIDTH-1:0] hit_data_t;

    typedef logic [`TAG_WIDTH-1:0] hit_tag_t;

    // Tag in the upper bits, payload in the lower bits
    typedef logic [`TAG_WIDTH+`HIT_WIDTH-1:0] tagged_word_t;

    // First word of a pair in the lower half
    typedef logic [2*(`TAG_WIDTH+`HIT_WIDTH)-1:0] packed_word_t;

    typedef logic [`LEVEL_WIDTH-1:0] fifo_level_t;

    typedef enum logic {
        EMPTY_HALF,
        LOW_HALF_HELD
    } packer_state_t;

endpackage

// File: readout_config.svh
// Readout path configuration macros
// Hit payload and sequence tag widths
// FIFO depth and the matching fill-level width

`ifndef READOUT_CONFIG_SVH
`define READOUT_CONFIG_SVH

// Raw hit payload bits
`define HIT_WIDTH 12

// Running sequence tag bits, wraps modulo 2**TAG_WIDTH
`define TAG_WIDTH 4

// FIFO entries, power of two
`define FIFO_DEPTH 8

// Fill level bits, log2 of FIFO_DEPTH
`define LEVEL_WIDTH 3

`endif
